/* mvutop.f */
+incdir+rtl
rtl/mvu_pkg.sv
rtl/mvu_tile_if.sv
rtl/mvu_cfg_dispatch.sv
rtl/mvu_controller.sv
rtl/mvu_agu.sv
rtl/mvu_mem.sv
rtl/mvu_dotprod.sv
rtl/mvu_tile.sv
rtl/mvu_result_collect.sv
rtl/mvutop.sv
verif/mvutop_tb.sv

/* verif/mvutop_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvutop_tb;

    localparam int DEPTH = 1 << `MVU_BADDR;

    logic                       mvu_ext;
    logic                       rst_n;
    logic                       wr_en;
    mvu_pkg::tile_id_t          wr_tile;
    mvu_pkg::mem_sel_e          wr_sel;
    mvu_pkg::addr_t             wr_addr;
    mvu_pkg::w_word_t           wr_wword;
    mvu_pkg::d_word_t           wr_dword;
    logic [`MVU_NMVU-1:0]       start;
    mvu_pkg::tile_cfg_t         cfg [`MVU_NMVU];
    logic                       result_valid;
    mvu_pkg::tile_id_t          result_tile;
    mvu_pkg::acc_t              result_value;
    logic [`MVU_NMVU-1:0]       done;
    logic [`MVU_NMVU-1:0]       irq;

    mvu_pkg::w_word_t           w_shadow [`MVU_NMVU][DEPTH];    // Copies of the tile memories
    mvu_pkg::d_word_t           d_shadow [`MVU_NMVU][DEPTH];
    integer                     seed;

    mvutop dut (
        .mvu_ext      (mvu_ext),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_tile      (wr_tile),
        .wr_sel       (wr_sel),
        .wr_addr      (wr_addr),
        .wr_wword     (wr_wword),
        .wr_dword     (wr_dword),
        .start        (start),
        .cfg          (cfg),
        .result_valid (result_valid),
        .result_tile  (result_tile),
        .result_value (result_value),
        .done         (done),
        .irq          (irq)
    );

    initial begin
        mvu_ext = 1'b0;
        forever #50 mvu_ext = ~mvu_ext;
    end

    // Inputs change 10 ns after the edge
    task automatic next_cycle();
        @(posedge mvu_ext);
        #10;
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic signed [31:0] got, input logic signed [31:0] expected,
                         input string msg);
        if (got !== expected) begin
            stop_run($sformatf("FAIL at %0t: %s (got %0d, expected %0d)",
                               $time, msg, got, expected));
        end
    endtask

    function automatic mvu_pkg::tile_cfg_t make_cfg(input int cd, input int wb,
                                                    input int ib, input int ij);
        mvu_pkg::tile_cfg_t c;
        c.countdown = cd[`MVU_BCNTDWN-1:0];
        c.wbaseaddr = mvu_pkg::addr_t'(wb);
        c.ibaseaddr = mvu_pkg::addr_t'(ib);
        c.ijump     = mvu_pkg::addr_t'(ij);
        return c;
    endfunction

    // Signed lane products over all steps with address wrap
    function automatic int expected_sum(input int t, input mvu_pkg::tile_cfg_t c);
        int acc;
        int wv;
        int dv;
        int wa;
        int ia;
        acc = 0;
        for (int k = 0; k <= c.countdown; k++) begin
            wa = (c.wbaseaddr + k) % DEPTH;
            ia = (c.ibaseaddr + k * c.ijump) % DEPTH;
            for (int l = 0; l < `MVU_LANES; l++) begin
                wv = $signed(w_shadow[t][wa][l]);
                dv = $signed(d_shadow[t][ia][l]);
                acc = acc + wv * dv;
            end
        end
        return acc;
    endfunction

    task automatic write_word(input int t, input mvu_pkg::mem_sel_e sel, input int a);
        wr_en    = 1'b1;
        wr_tile  = mvu_pkg::tile_id_t'(t);
        wr_sel   = sel;
        wr_addr  = mvu_pkg::addr_t'(a);
        wr_wword = w_shadow[t][a];
        wr_dword = d_shadow[t][a];
        next_cycle();
        wr_en    = 1'b0;
    endtask

    task automatic load_words(input int t, input int first_addr, input int count);
        int a;
        for (int i = 0; i < count; i++) begin
            a = (first_addr + i) % DEPTH;
            w_shadow[t][a] = mvu_pkg::w_word_t'($random(seed));
            d_shadow[t][a] = mvu_pkg::d_word_t'($random(seed));
            write_word(t, mvu_pkg::MEM_WEIGHT, a);
            write_word(t, mvu_pkg::MEM_INPUT, a);
        end
    endtask

    // One job on an idle tile
    task automatic run_single(input int t, input mvu_pkg::tile_cfg_t c);
        int n;
        int irq_cnt;
        int want;
        want     = expected_sum(t, c);
        cfg[t]   = c;
        start[t] = 1'b1;
        n        = 0;
        irq_cnt  = 0;
        do begin
            next_cycle();
            n++;
            start[t] = 1'b0;
            if (irq[t]) begin
                irq_cnt++;
            end
            if (n == 2) begin
                check(done[t], 0, "done low while the job runs");
            end
            if (n > c.countdown + 20) begin
                stop_run($sformatf("Timeout waiting for the result of tile %0d", t));
            end
        end while (!result_valid);
        check(n, c.countdown + 7, "start to result latency");
        check(result_tile, t, "result tile id");
        check(result_value, want, "dot product sum");
        check(irq_cnt, 1, "irq pulses per job");
        check(done[t], 1, "done after the result");
    endtask

    task automatic test_reset_state();
        check(result_valid, 0, "result_valid after reset");
        check(done, 0, "done after reset");
        check(irq, 0, "irq after reset");
    endtask

    task automatic test_single_job();
        run_single(1, make_cfg(7, 3, 16, 1));
    endtask

    task automatic test_wrap();
        run_single(0, make_cfg(0, 12, 45, 1));      // Single step
        run_single(3, make_cfg(9, 60, 50, 3));      // Both addresses pass 63
    endtask

    task automatic test_all_tiles();
        mvu_pkg::tile_cfg_t jobs [`MVU_NMVU];
        int want [`MVU_NMVU];
        bit seen [`MVU_NMVU];
        int got;
        int n;
        int limit;
        jobs[0] = make_cfg(6, 0, 10, 1);
        jobs[1] = make_cfg(3, 20, 40, 2);
        jobs[2] = make_cfg(9, 55, 5, 5);
        jobs[3] = make_cfg(6, 33, 63, 7);
        limit = 0;
        for (int t = 0; t < `MVU_NMVU; t++) begin
            want[t] = expected_sum(t, jobs[t]);
            cfg[t]  = jobs[t];
            seen[t] = 1'b0;
            if (jobs[t].countdown + 11 > limit) begin
                limit = jobs[t].countdown + 11;
            end
        end
        start = '1;
        got   = 0;
        n     = 0;
        while (got < `MVU_NMVU) begin
            next_cycle();
            n++;
            start = '0;
            if (n > limit) begin
                stop_run("Timeout waiting for the results of all four tiles");
            end
            if (result_valid) begin
                check(seen[result_tile], 0, "tile id reported twice");
                seen[result_tile] = 1'b1;
                check(result_value, want[result_tile], "sum of a concurrent job");
                got++;
            end
        end
    endtask

    task automatic test_irq_done();
        run_single(2, make_cfg(4, 7, 30, 2));
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            check(done[2], 1, "done held after the result");
            check(irq[2], 0, "irq beyond its single pulse");
        end
        load_words(2, 40, 12);                      // Fresh data while idle
        run_single(2, make_cfg(11, 40, 12, 3));
    endtask

    initial begin
        seed     = 32'h8945b905;
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        wr_tile  = '0;
        wr_sel   = mvu_pkg::MEM_WEIGHT;
        wr_addr  = '0;
        wr_wword = '0;
        wr_dword = '0;
        start    = '0;
        for (int t = 0; t < `MVU_NMVU; t++) begin
            cfg[t] = '0;
        end
        repeat (5) @(posedge mvu_ext);
        #10;
        rst_n = 1'b1;
        next_cycle();
        test_reset_state();
        for (int t = 0; t < `MVU_NMVU; t++) begin
            load_words(t, 0, DEPTH);
        end
        test_single_job();
        test_wrap();
        test_all_tiles();
        test_irq_done();
        next_cycle();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mvutop.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvutop (
    input  wire logic                   mvu_ext,
    input  wire logic                   rst_n,
    input  wire logic                   wr_en,
    input  wire mvu_pkg::tile_id_t      wr_tile,
    input  wire mvu_pkg::mem_sel_e      wr_sel,
    input  wire mvu_pkg::addr_t         wr_addr,
    input  wire mvu_pkg::w_word_t       wr_wword,
    input  wire mvu_pkg::d_word_t       wr_dword,
    input  wire logic [`MVU_NMVU-1:0]   start,
    input  wire mvu_pkg::tile_cfg_t     cfg [`MVU_NMVU],
    output wire logic                   result_valid,
    output wire mvu_pkg::tile_id_t      result_tile,
    output wire mvu_pkg::acc_t          result_value,
    output wire logic [`MVU_NMVU-1:0]   done,
    output wire logic [`MVU_NMVU-1:0]   irq
);

    mvu_tile_if link [`MVU_NMVU] ();

    mvu_cfg_dispatch u_dispatch (
        .mvu_ext  (mvu_ext),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_tile  (wr_tile),
        .wr_sel   (wr_sel),
        .wr_addr  (wr_addr),
        .wr_wword (wr_wword),
        .wr_dword (wr_dword),
        .start    (start),
        .cfg      (cfg),
        .tiles    (link)
    );

    genvar i;

    for (i = 0; i < `MVU_NMVU; i = i + 1) begin : g_tile
        mvu_tile u_tile (
            .mvu_ext (mvu_ext),
            .rst_n   (rst_n),
            .link    (link[i]),
            .done    (done[i]),
            .irq     (irq[i])
        );
    end

    mvu_result_collect u_collect (
        .mvu_ext      (mvu_ext),
        .rst_n        (rst_n),
        .tiles        (link),
        .result_valid (result_valid),
        .result_tile  (result_tile),
        .result_value (result_value)
    );

endmodule

`default_nettype wire

/* rtl/mvu_result_collect.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_result_collect (
    input  wire logic           mvu_ext,
    input  wire logic           rst_n,
    mvu_tile_if.coll            tiles [`MVU_NMVU],
    output logic                result_valid,
    output mvu_pkg::tile_id_t   result_tile,
    output mvu_pkg::acc_t       result_value
);

    logic [`MVU_NMVU-1:0]   in_valid;
    mvu_pkg::acc_t          in_value [`MVU_NMVU];
    logic [`MVU_NMVU-1:0]   pend_q;                 // Holding slot full
    mvu_pkg::acc_t          hold_q [`MVU_NMVU];
    logic [`MVU_NMVU-1:0]   req;
    logic [`MVU_NMVU-1:0]   gnt_vec;
    logic                   gnt_any;
    mvu_pkg::tile_id_t      gnt_id;
    mvu_pkg::tile_id_t      ptr_q;                  // Last granted tile
    mvu_pkg::acc_t          gnt_value;

    genvar i;

    for (i = 0; i < `MVU_NMVU; i = i + 1) begin : g_in
        assign in_valid[i] = tiles[i].res_valid;
        assign in_value[i] = tiles[i].res_value;

        // One slot per tile, a tile never has two results waiting
        a_no_overrun: assert property (@(posedge mvu_ext) disable iff (!rst_n)
            in_valid[i] |-> !pend_q[i])
            else $error("mvu_result_collect: tile %0d result while slot full", i);
    end

    assign req = pend_q | in_valid;     // Fresh results can go out at once

    // Round robin, search starts after the last grant
    always_comb begin
        mvu_pkg::tile_id_t idx;
        gnt_any = 1'b0;
        gnt_id  = ptr_q;
        for (int k = 1; k <= `MVU_NMVU; k++) begin
            idx = mvu_pkg::tile_id_t'(ptr_q + k);
            if (!gnt_any && req[idx]) begin
                gnt_any = 1'b1;
                gnt_id  = idx;
            end
        end
    end

    assign gnt_vec   = gnt_any ? (`MVU_NMVU'(1) << gnt_id) : '0;
    assign gnt_value = pend_q[gnt_id] ? hold_q[gnt_id] : in_value[gnt_id];

    always_ff @(posedge mvu_ext) begin
        for (int k = 0; k < `MVU_NMVU; k++) begin
            if (in_valid[k]) begin
                hold_q[k] <= in_value[k];
            end
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            pend_q       <= '0;
            ptr_q        <= mvu_pkg::tile_id_t'(`MVU_NMVU - 1);     // Tile 0 goes first
            result_valid <= 1'b0;
            result_tile  <= '0;
        end else begin
            pend_q       <= req & ~gnt_vec;
            result_valid <= gnt_any;
            if (gnt_any) begin
                ptr_q       <= gnt_id;
                result_tile <= gnt_id;
            end
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (gnt_any) begin
            result_value <= gnt_value;
        end
    end

endmodule

`default_nettype wire

/* rtl/mvu_tile.sv */
`timescale 1ns/100ps
`default_nettype none

module mvu_tile (
    input  wire logic   mvu_ext,
    input  wire logic   rst_n,
    mvu_tile_if.tile    link,
    output logic        done,
    output logic        irq
);

    logic               run;
    logic               first;
    logic               last;
    mvu_pkg::addr_t     waddr;
    mvu_pkg::addr_t     iaddr;
    mvu_pkg::w_word_t   wword;
    mvu_pkg::d_word_t   dword;
    logic               valid_d;        // Step flags aligned to read data
    logic               first_d;
    logic               last_d;
    logic               we_w;
    logic               we_d;

    assign we_w = link.wr_en && (link.wr_sel == mvu_pkg::MEM_WEIGHT);
    assign we_d = link.wr_en && (link.wr_sel == mvu_pkg::MEM_INPUT);

    mvu_controller u_ctrl (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .start     (link.job_start),
        .countdown (link.job_cfg.countdown),
        .acc_last  (link.res_valid),
        .run       (run),
        .first     (first),
        .last      (last),
        .done      (done),
        .irq       (irq)
    );

    mvu_agu u_agu (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .start     (link.job_start),
        .run       (run),
        .wbaseaddr (link.job_cfg.wbaseaddr),
        .ibaseaddr (link.job_cfg.ibaseaddr),
        .ijump     (link.job_cfg.ijump),
        .waddr     (waddr),
        .iaddr     (iaddr)
    );

    mvu_mem #(.word_t(mvu_pkg::w_word_t)) u_wmem (
        .mvu_ext (mvu_ext),
        .wr_en   (we_w),
        .wr_addr (link.wr_addr),
        .wr_word (link.wr_wword),
        .rd_addr (waddr),
        .rd_word (wword)
    );

    mvu_mem #(.word_t(mvu_pkg::d_word_t)) u_dmem (
        .mvu_ext (mvu_ext),
        .wr_en   (we_d),
        .wr_addr (link.wr_addr),
        .wr_word (link.wr_dword),
        .rd_addr (iaddr),
        .rd_word (dword)
    );

    // Match the memory read latency
    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            first_d <= 1'b0;
            last_d  <= 1'b0;
        end else begin
            valid_d <= run;
            first_d <= first;
            last_d  <= last;
        end
    end

    mvu_dotprod u_dot (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .valid     (valid_d),
        .first     (first_d),
        .last      (last_d),
        .wword     (wword),
        .dword     (dword),
        .res_valid (link.res_valid),
        .res_value (link.res_value)
    );

endmodule

`default_nettype wire

/* rtl/mvu_dotprod.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_dotprod (
    input  wire logic               mvu_ext,
    input  wire logic               rst_n,
    input  wire logic               valid,
    input  wire logic               first,
    input  wire logic               last,
    input  wire mvu_pkg::w_word_t   wword,
    input  wire mvu_pkg::d_word_t   dword,
    output logic                    res_valid,
    output mvu_pkg::acc_t           res_value
);

    localparam int BPROD = `MVU_BWPREC + `MVU_BDPREC;

    logic signed [BPROD-1:0]    prod_q [`MVU_LANES];    // Stage 1 lane products
    logic                       v1_q;
    logic                       f1_q;
    logic                       l1_q;
    logic                       l2_q;                   // Final accumulate done
    mvu_pkg::acc_t              lane_sum;
    mvu_pkg::acc_t              acc_q;

    always_ff @(posedge mvu_ext) begin
        for (int l = 0; l < `MVU_LANES; l++) begin
            prod_q[l] <= $signed(wword[l]) * $signed(dword[l]);
        end
    end

    // Sign extended adder tree of the lane products
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < `MVU_LANES; l++) begin
            lane_sum = lane_sum + prod_q[l];
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            v1_q      <= 1'b0;
            f1_q      <= 1'b0;
            l1_q      <= 1'b0;
            l2_q      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            v1_q      <= valid;
            f1_q      <= valid && first;
            l1_q      <= valid && last;
            l2_q      <= l1_q;
            res_valid <= l2_q;
        end
    end

    // Stage 2, first step of a job restarts the sum
    always_ff @(posedge mvu_ext) begin
        if (v1_q) begin
            acc_q <= f1_q ? lane_sum : acc_q + lane_sum;
        end
    end

    // Frees acc_q for the next job right away
    always_ff @(posedge mvu_ext) begin
        if (l2_q) begin
            res_value <= acc_q;
        end
    end

endmodule

`default_nettype wire

/* rtl/mvu_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_mem #(
    parameter type word_t = logic [7:0]
) (
    input  wire logic               mvu_ext,
    input  wire logic               wr_en,
    input  wire mvu_pkg::addr_t     wr_addr,
    input  wire word_t              wr_word,
    input  wire mvu_pkg::addr_t     rd_addr,
    output word_t                   rd_word
);

    localparam int DEPTH = 1 << `MVU_BADDR;

    word_t mem [DEPTH];

    always_ff @(posedge mvu_ext) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // One cycle read latency
    always_ff @(posedge mvu_ext) begin
        rd_word <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* rtl/mvu_agu.sv */
`timescale 1ns/100ps
`default_nettype none

module mvu_agu (
    input  wire logic               mvu_ext,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               run,
    input  wire mvu_pkg::addr_t     wbaseaddr,
    input  wire mvu_pkg::addr_t     ibaseaddr,
    input  wire mvu_pkg::addr_t     ijump,
    output mvu_pkg::addr_t          waddr,
    output mvu_pkg::addr_t          iaddr
);

    // Addresses wrap at the top of the memory
    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            waddr <= '0;
            iaddr <= '0;
        end else if (start) begin
            waddr <= wbaseaddr;             // Valid in the first run cycle
            iaddr <= ibaseaddr;
        end else if (run) begin
            waddr <= waddr + 1'b1;          // Weights are contiguous
            iaddr <= iaddr + ijump;         // Inputs use a stride
        end
    end

endmodule

`default_nettype wire

/* rtl/mvu_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_controller (
    input  wire logic                       mvu_ext,
    input  wire logic                       rst_n,
    input  wire logic                       start,
    input  wire logic [`MVU_BCNTDWN-1:0]    countdown,
    input  wire logic                       acc_last,
    output logic                            run,
    output logic                            first,
    output logic                            last,
    output logic                            done,
    output logic                            irq
);

    logic [`MVU_BCNTDWN-1:0]    cnt_q;      // Remaining steps after this one
    logic                       busy_q;     // Job between start and result
    logic                       done_q;

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            run    <= 1'b0;
            first  <= 1'b0;
            cnt_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (irq) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (start) begin
                run    <= 1'b1;
                first  <= 1'b1;
                cnt_q  <= countdown;
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (run) begin
                first <= 1'b0;
                if (cnt_q == '0) begin
                    run <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    assign last = run && (cnt_q == '0);
    assign irq  = acc_last && busy_q;       // Result of our own job only
    assign done = done_q || irq;

    // A second job must wait for the result
    a_start_idle: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        start |-> !busy_q)
        else $error("mvu_controller: start while a job is in flight");

    // The dot product reports a job only after its run phase
    a_result_owned: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        acc_last |-> busy_q && !run)
        else $error("mvu_controller: result strobe outside a finished job");

endmodule

`default_nettype wire

/* rtl/mvu_cfg_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_cfg_dispatch (
    input  wire logic                   mvu_ext,
    input  wire logic                   rst_n,
    input  wire logic                   wr_en,
    input  wire mvu_pkg::tile_id_t      wr_tile,
    input  wire mvu_pkg::mem_sel_e      wr_sel,
    input  wire mvu_pkg::addr_t         wr_addr,
    input  wire mvu_pkg::w_word_t       wr_wword,
    input  wire mvu_pkg::d_word_t       wr_dword,
    input  wire logic [`MVU_NMVU-1:0]   start,
    input  wire mvu_pkg::tile_cfg_t     cfg [`MVU_NMVU],
    mvu_tile_if.disp                    tiles [`MVU_NMVU]
);

    genvar i;

    for (i = 0; i < `MVU_NMVU; i = i + 1) begin : g_tile

        // Start delayed one cycle to line up with the buffered config
        always_ff @(posedge mvu_ext or negedge rst_n) begin
            if (!rst_n) begin
                tiles[i].job_start <= 1'b0;
            end else begin
                tiles[i].job_start <= start[i];
            end
        end

        // Parameter buffer
        always_ff @(posedge mvu_ext) begin
            if (start[i]) begin
                tiles[i].job_cfg <= cfg[i];
            end
        end

        // Write port, only the enable is tile specific
        assign tiles[i].wr_en    = wr_en && (wr_tile == mvu_pkg::tile_id_t'(i));
        assign tiles[i].wr_sel   = wr_sel;
        assign tiles[i].wr_addr  = wr_addr;
        assign tiles[i].wr_wword = wr_wword;
        assign tiles[i].wr_dword = wr_dword;

    end

endmodule

`default_nettype wire

/* rtl/mvu_tile_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mvu_tile_if;

    logic                   job_start;      // One-cycle pulse
    mvu_pkg::tile_cfg_t     job_cfg;        // Held until next job_start

    // Write port, already decoded for this tile
    logic                   wr_en;
    mvu_pkg::mem_sel_e      wr_sel;
    mvu_pkg::addr_t         wr_addr;
    mvu_pkg::w_word_t       wr_wword;
    mvu_pkg::d_word_t       wr_dword;

    logic                   res_valid;      // One-cycle pulse
    mvu_pkg::acc_t          res_value;

    modport disp (output job_start, job_cfg, wr_en, wr_sel, wr_addr, wr_wword, wr_dword);

    modport tile (input  job_start, job_cfg, wr_en, wr_sel, wr_addr, wr_wword, wr_dword,
                  output res_valid, res_value);

    modport coll (input res_valid, res_value);

endinterface

`default_nettype wire

/* rtl/mvu_pkg.sv */
`default_nettype none

`include "mvu_defines.svh"

package mvu_pkg;

    // Lanes are signed, packed lane 0 in the low bits
    typedef logic [`MVU_LANES-1:0][`MVU_BWPREC-1:0] w_word_t;
    typedef logic [`MVU_LANES-1:0][`MVU_BDPREC-1:0] d_word_t;

    typedef logic [`MVU_BADDR-1:0]              addr_t;
    typedef logic signed [`MVU_BACC-1:0]        acc_t;
    typedef logic [$clog2(`MVU_NMVU)-1:0]       tile_id_t;

    typedef struct packed {
        logic [`MVU_BCNTDWN-1:0] countdown;     // Steps minus one
        addr_t                   wbaseaddr;     // First weight word
        addr_t                   ibaseaddr;     // First input word
        addr_t                   ijump;         // Input stride per step
    } tile_cfg_t;

    typedef enum logic {
        MEM_WEIGHT = 1'b0,
        MEM_INPUT  = 1'b1
    } mem_sel_e;

endpackage

`default_nettype wire

/* rtl/mvu_defines.svh */
`ifndef MVU_DEFINES_SVH
`define MVU_DEFINES_SVH

// Tile count
`define MVU_NMVU     4

// Memory word layout
`define MVU_LANES    4
`define MVU_BWPREC   4
`define MVU_BDPREC   8

// Address, countdown and accumulator widths
`define MVU_BADDR    6
`define MVU_BCNTDWN  6
`define MVU_BACC     24

`endif
